// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --top-module instrDecoderTb -f src.f -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== logic/aluOpDecoder.sv ====
`timescale 1ns/1ns

module aluOpDecoder (
    input  decodePkg::opClassE                                 opClass,
    input  logic [decodePkg::funct3Msb-decodePkg::funct3Lsb:0] funct3,
    input  logic [decodePkg::funct7Msb-decodePkg::funct7Lsb:0] funct7,
    output decodePkg::aluOpE                                   aluOp,
    output logic                                               badFunct
);

    always_comb begin
        aluOp    = decodePkg::aluNone;
        badFunct = 1'b0;
        case (opClass)
            decodePkg::classAuipc, decodePkg::classLoad,
            decodePkg::classStore, decodePkg::classJalr: begin
                aluOp = decodePkg::aluAdd;           // address or pc sum
            end
            decodePkg::classOp, decodePkg::classOpImm: begin
                case (funct3)
                    3'b000: begin
                        // addi has an immediate here, not a funct7
                        if (opClass == decodePkg::classOpImm ||
                            funct7 == decodePkg::funct7Base) begin
                            aluOp = decodePkg::aluAdd;
                        end else if (funct7 == decodePkg::funct7Alt) begin
                            aluOp = decodePkg::aluSub;
                        end else begin
                            badFunct = 1'b1;
                        end
                    end
                    3'b001: begin
                        if (funct7 == decodePkg::funct7Base) begin
                            aluOp = decodePkg::aluShiftL;
                        end else begin
                            badFunct = 1'b1;
                        end
                    end
                    3'b010: aluOp = decodePkg::aluLessThanSigned;  // slt/slti
                    3'b011: aluOp = decodePkg::aluLessThan;        // sltu/sltiu
                    3'b100: aluOp = decodePkg::aluXor;
                    3'b101: begin
                        if (funct7 == decodePkg::funct7Base) begin
                            aluOp = decodePkg::aluShiftR;
                        end else if (funct7 == decodePkg::funct7Alt) begin
                            aluOp = decodePkg::aluShiftRArith;
                        end else begin
                            badFunct = 1'b1;
                        end
                    end
                    3'b110: aluOp = decodePkg::aluOr;
                    default: aluOp = decodePkg::aluAnd;            // 3'b111
                endcase
            end
            default: aluOp = decodePkg::aluNone;   // lui, branch, jal, unknown
        endcase
    end

endmodule

// ==== logic/decodePkg.sv ====
package decodePkg;

    // ----------------------------------------
    // instruction layout
    // ----------------------------------------
    parameter int instrWidth = 32;
    parameter int opcodeLsb  = 0;
    parameter int opcodeMsb  = 6;
    parameter int funct3Lsb  = 12;
    parameter int funct3Msb  = 14;
    parameter int funct7Lsb  = 25;
    parameter int funct7Msb  = 31;

    // major opcodes, rv32i integer subset
    parameter logic [opcodeMsb-opcodeLsb:0] opLui    = 7'b0110111;
    parameter logic [opcodeMsb-opcodeLsb:0] opAuipc  = 7'b0010111;
    parameter logic [opcodeMsb-opcodeLsb:0] opOpImm  = 7'b0010011;
    parameter logic [opcodeMsb-opcodeLsb:0] opOp     = 7'b0110011;
    parameter logic [opcodeMsb-opcodeLsb:0] opLoad   = 7'b0000011;
    parameter logic [opcodeMsb-opcodeLsb:0] opStore  = 7'b0100011;
    parameter logic [opcodeMsb-opcodeLsb:0] opBranch = 7'b1100011;
    parameter logic [opcodeMsb-opcodeLsb:0] opJal    = 7'b1101111;
    parameter logic [opcodeMsb-opcodeLsb:0] opJalr   = 7'b1100111;

    parameter logic [funct7Msb-funct7Lsb:0] funct7Base = 7'b0000000;
    parameter logic [funct7Msb-funct7Lsb:0] funct7Alt  = 7'b0100000; // sub, sra, srai

    // ----------------------------------------
    // decoder enums
    // ----------------------------------------
    typedef enum logic [3:0] {
        classLui    = 4'd0,
        classAuipc  = 4'd1,
        classOpImm  = 4'd2,
        classOp     = 4'd3,
        classLoad   = 4'd4,
        classStore  = 4'd5,
        classBranch = 4'd6,
        classJal    = 4'd7,
        classJalr   = 4'd8,
        classNone   = 4'd9  // unknown opcode
    } opClassE;

    typedef enum logic [2:0] {
        typeR = 3'd0,
        typeI = 3'd1,
        typeS = 3'd2,
        typeB = 3'd3,
        typeU = 3'd4,
        typeJ = 3'd5
    } instrTypeE;

    typedef enum logic [4:0] {
        aluNone           = 5'd0,
        aluShiftL         = 5'd1,
        aluShiftR         = 5'd2,
        aluShiftRArith    = 5'd3,
        aluAdd            = 5'd4,
        aluSub            = 5'd5,
        aluAnd            = 5'd6,
        aluOr             = 5'd7,
        aluXor            = 5'd8,
        aluLessThan       = 5'd9,  // unsigned compare
        aluLessThanSigned = 5'd10
    } aluOpE;

    typedef enum logic [2:0] {
        dByte  = 3'd0,
        dHalf  = 3'd1,
        dWord  = 3'd2,
        dByteU = 3'd3,
        dHalfU = 3'd4
    } dTypeE;

    typedef enum logic [2:0] {
        brEq  = 3'd0,
        brNe  = 3'd1,
        brLt  = 3'd2,
        brGe  = 3'd3,
        brLtu = 3'd4,
        brGeu = 3'd5
    } branchTypeE;

endpackage

// ==== logic/decodeRegister.sv ====
`timescale 1ns/1ns

module decodeRegister (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         instrValid,
    input  decodePkg::aluOpE             nextAluOp,
    input  decodePkg::instrTypeE         nextInstrType,
    input  decodePkg::dTypeE             nextDType,
    input  decodePkg::branchTypeE        nextBranchType,
    input  logic                         nextRegWrite,
    input  logic                         nextMemWrite,
    input  logic                         nextLoad,
    input  logic                         nextJump,
    input  logic                         nextAuipc,
    input  logic                         badOpcode,
    input  logic                         badFunct,
    input  logic                         badFunct3,
    output logic                         decValid,
    output decodePkg::aluOpE             aluOp,
    output decodePkg::instrTypeE         instrType,
    output decodePkg::dTypeE             dType,
    output decodePkg::branchTypeE        branchType,
    output logic                         regWrite,
    output logic                         memWrite,
    output logic                         load,
    output logic                         jump,
    output logic                         auipc,
    output logic                         illegal
);

    logic badAny;

    assign badAny = badOpcode | badFunct | badFunct3;

    // ----------------------------------------
    // capture on strobe, hold otherwise
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid   <= 1'b0;
            aluOp      <= decodePkg::aluNone;
            instrType  <= decodePkg::typeR;
            dType      <= decodePkg::dByte;
            branchType <= decodePkg::brEq;
            regWrite   <= 1'b0;
            memWrite   <= 1'b0;
            load       <= 1'b0;
            jump       <= 1'b0;
            auipc      <= 1'b0;
            illegal    <= 1'b0;
        end else begin
            decValid <= instrValid;                  // one pulse per strobe
            if (instrValid) begin
                aluOp      <= badAny ? decodePkg::aluNone : nextAluOp;
                instrType  <= nextInstrType;
                dType      <= nextDType;
                branchType <= nextBranchType;
                regWrite   <= nextRegWrite & ~badAny;  // no side effects when illegal
                memWrite   <= nextMemWrite & ~badAny;
                load       <= nextLoad & ~badAny;
                jump       <= nextJump & ~badAny;
                auipc      <= nextAuipc & ~badAny;
                illegal    <= badAny;
            end
        end
    end

endmodule

// ==== logic/instrDecoder.sv ====
`timescale 1ns/1ns

module instrDecoder (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             instrValid,
    input  logic [decodePkg::instrWidth-1:0] instr,
    output logic                             decValid,
    output decodePkg::aluOpE                 aluOp,
    output decodePkg::instrTypeE             instrType,
    output decodePkg::dTypeE                 dType,
    output decodePkg::branchTypeE            branchType,
    output logic                             regWrite,
    output logic                             memWrite,
    output logic                             load,
    output logic                             jump,
    output logic                             auipc,
    output logic                             illegal
);

    // ----------------------------------------
    // instruction fields
    // ----------------------------------------
    logic [decodePkg::opcodeMsb-decodePkg::opcodeLsb:0] opcode;
    logic [decodePkg::funct3Msb-decodePkg::funct3Lsb:0] funct3;
    logic [decodePkg::funct7Msb-decodePkg::funct7Lsb:0] funct7;

    assign opcode = instr[decodePkg::opcodeMsb:decodePkg::opcodeLsb];
    assign funct3 = instr[decodePkg::funct3Msb:decodePkg::funct3Lsb];
    assign funct7 = instr[decodePkg::funct7Msb:decodePkg::funct7Lsb];

    // combinational decode results
    decodePkg::opClassE     opClass;
    decodePkg::instrTypeE   classType;
    decodePkg::aluOpE       decAluOp;
    decodePkg::dTypeE       decDType;
    decodePkg::branchTypeE  decBranchType;
    logic                   classRegWrite;
    logic                   classMemWrite;
    logic                   classLoad;
    logic                   classJump;
    logic                   classAuipc;
    logic                   badOpcode;
    logic                   badFunct;
    logic                   badFunct3;

    opcodeClassifier opcodeClassifier_i (
        .opcode    (opcode),
        .opClass   (opClass),
        .instrType (classType),
        .regWrite  (classRegWrite),
        .memWrite  (classMemWrite),
        .load      (classLoad),
        .jump      (classJump),
        .auipc     (classAuipc),
        .badOpcode (badOpcode)
    );

    aluOpDecoder aluOpDecoder_i (
        .opClass  (opClass),
        .funct3   (funct3),
        .funct7   (funct7),
        .aluOp    (decAluOp),
        .badFunct (badFunct)
    );

    memBranchDecoder memBranchDecoder_i (
        .opClass    (opClass),
        .funct3     (funct3),
        .dType      (decDType),
        .branchType (decBranchType),
        .badFunct3  (badFunct3)
    );

    decodeRegister decodeRegister_i (
        .clk            (clk),
        .rstN           (rstN),
        .instrValid     (instrValid),
        .nextAluOp      (decAluOp),
        .nextInstrType  (classType),
        .nextDType      (decDType),
        .nextBranchType (decBranchType),
        .nextRegWrite   (classRegWrite),
        .nextMemWrite   (classMemWrite),
        .nextLoad       (classLoad),
        .nextJump       (classJump),
        .nextAuipc      (classAuipc),
        .badOpcode      (badOpcode),
        .badFunct       (badFunct),
        .badFunct3      (badFunct3),
        .decValid       (decValid),
        .aluOp          (aluOp),
        .instrType      (instrType),
        .dType          (dType),
        .branchType     (branchType),
        .regWrite       (regWrite),
        .memWrite       (memWrite),
        .load           (load),
        .jump           (jump),
        .auipc          (auipc),
        .illegal        (illegal)
    );

endmodule

// ==== logic/memBranchDecoder.sv ====
`timescale 1ns/1ns

module memBranchDecoder (
    input  decodePkg::opClassE                                 opClass,
    input  logic [decodePkg::funct3Msb-decodePkg::funct3Lsb:0] funct3,
    output decodePkg::dTypeE                                   dType,
    output decodePkg::branchTypeE                              branchType,
    output logic                                               badFunct3
);

    always_comb begin
        dType      = decodePkg::dByte;
        branchType = decodePkg::brEq;
        badFunct3  = 1'b0;
        case (opClass)
            decodePkg::classLoad: begin
                case (funct3)
                    3'b000:  dType = decodePkg::dByte;
                    3'b001:  dType = decodePkg::dHalf;
                    3'b010:  dType = decodePkg::dWord;
                    3'b100:  dType = decodePkg::dByteU;
                    3'b101:  dType = decodePkg::dHalfU;
                    default: badFunct3 = 1'b1;       // 011, 110, 111
                endcase
            end
            decodePkg::classStore: begin
                case (funct3)
                    3'b000:  dType = decodePkg::dByte;
                    3'b001:  dType = decodePkg::dHalf;
                    3'b010:  dType = decodePkg::dWord;
                    default: badFunct3 = 1'b1;       // no unsigned stores
                endcase
            end
            decodePkg::classBranch: begin
                case (funct3)
                    3'b000:  branchType = decodePkg::brEq;
                    3'b001:  branchType = decodePkg::brNe;
                    3'b100:  branchType = decodePkg::brLt;
                    3'b101:  branchType = decodePkg::brGe;
                    3'b110:  branchType = decodePkg::brLtu;
                    3'b111:  branchType = decodePkg::brGeu;
                    default: badFunct3 = 1'b1;       // 010, 011
                endcase
            end
            default: badFunct3 = 1'b0;               // funct3 not used for width
        endcase
    end

endmodule

// ==== logic/opcodeClassifier.sv ====
`timescale 1ns/1ns

module opcodeClassifier (
    input  logic [decodePkg::opcodeMsb-decodePkg::opcodeLsb:0] opcode,
    output decodePkg::opClassE                                 opClass,
    output decodePkg::instrTypeE                               instrType,
    output logic                                               regWrite,
    output logic                                               memWrite,
    output logic                                               load,
    output logic                                               jump,
    output logic                                               auipc,
    output logic                                               badOpcode
);

    always_comb begin
        opClass   = decodePkg::classNone;
        instrType = decodePkg::typeR;
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        load      = 1'b0;
        jump      = 1'b0;
        auipc     = 1'b0;
        badOpcode = 1'b0;
        case (opcode)
            decodePkg::opLui: begin
                opClass   = decodePkg::classLui;
                instrType = decodePkg::typeU;
                regWrite  = 1'b1;
            end
            decodePkg::opAuipc: begin
                opClass   = decodePkg::classAuipc;
                instrType = decodePkg::typeU;
                regWrite  = 1'b1;
                auipc     = 1'b1;                // pc-relative upper immediate
            end
            decodePkg::opOpImm: begin
                opClass   = decodePkg::classOpImm;
                instrType = decodePkg::typeI;
                regWrite  = 1'b1;
            end
            decodePkg::opOp: begin
                opClass   = decodePkg::classOp;
                instrType = decodePkg::typeR;
                regWrite  = 1'b1;
            end
            decodePkg::opLoad: begin
                opClass   = decodePkg::classLoad;
                instrType = decodePkg::typeI;
                regWrite  = 1'b1;
                load      = 1'b1;                // rd gets lsu data
            end
            decodePkg::opStore: begin
                opClass   = decodePkg::classStore;
                instrType = decodePkg::typeS;
                memWrite  = 1'b1;
            end
            decodePkg::opBranch: begin
                opClass   = decodePkg::classBranch;
                instrType = decodePkg::typeB;
            end
            decodePkg::opJal: begin
                opClass   = decodePkg::classJal;
                instrType = decodePkg::typeJ;
                regWrite  = 1'b1;                // link address
                jump      = 1'b1;
            end
            decodePkg::opJalr: begin
                opClass   = decodePkg::classJalr;
                instrType = decodePkg::typeI;
                regWrite  = 1'b1;
                jump      = 1'b1;
            end
            default: badOpcode = 1'b1;           // fp and custom opcodes land here
        endcase
    end

endmodule

// ==== src.f ====
logic/decodePkg.sv
logic/opcodeClassifier.sv
logic/aluOpDecoder.sv
logic/memBranchDecoder.sv
logic/decodeRegister.sv
logic/instrDecoder.sv
test/instrDecoderTb.sv

// ==== test/decodePatterns.txt ====
// instr[51:20] illegal[19] aluOp[18:14] instrType[13:11] dType[10:8]
// branchType[7:5] regWrite[4] memWrite[3] load[2] jump[1] auipc[0]
403100B314010  // sub x1, x2, x3
403150B30C010  // sra x1, x2, x3
0051009310810  // addi x1, x2, 5
403150930C810  // srai x1, x2, 3
0041008310814  // lb x1, 4(x2)
0041108310914  // lh x1, 4(x2)
0041208310A14  // lw x1, 4(x2)
0041408310B14  // lbu x1, 4(x2)
0041508310C14  // lhu x1, 4(x2)
0031042311008  // sb x3, 8(x2)
0031142311108  // sh x3, 8(x2)
0031242311208  // sw x3, 8(x2)
0031046301800  // beq x2, x3, 8
0031146301820  // bne x2, x3, 8
0031446301840  // blt x2, x3, 8
0031546301860  // bge x2, x3, 8
0031646301880  // bltu x2, x3, 8
00317463018A0  // bgeu x2, x3, 8
010000EF02812  // jal x1, 16
000100E710812  // jalr x1, 0(x2)
123450B702010  // lui x1, 0x12345
0000109712011  // auipc x1, 1
0001208780000  // flw f1, 0(x2), unknown opcode
0041308380800  // load funct3 011
0031246381800  // branch funct3 010
4031109380800  // slli with funct7 0100000

// ==== test/instrDecoderTb.sv ====
`timescale 1ns/1ns

module instrDecoderTb;

    localparam int numTests     = 26;
    localparam int timeoutLimit = numTests * 5 + 20;    // in clock cycles

    logic                             clk;
    logic                             rstN;
    logic                             instrValid;
    logic [decodePkg::instrWidth-1:0] instr;
    logic                             decValid;
    decodePkg::aluOpE                 aluOp;
    decodePkg::instrTypeE             instrType;
    decodePkg::dTypeE                 dType;
    decodePkg::branchTypeE            branchType;
    logic                             regWrite;
    logic                             memWrite;
    logic                             load;
    logic                             jump;
    logic                             auipc;
    logic                             illegal;

    logic [51:0] patterns [0:numTests-1];             // instr, then packed decode
    logic [19:0] actualBits;
    logic [19:0] lastOut     = '0;                    // reset values are all zero
    logic [31:0] lfsrState   = 32'heb4a;
    logic [1:0]  gap;
    logic        testBad;
    int          cycle       = 0;
    int          doneCount   = 0;
    int          passCount   = 0;
    int          failCount   = 0;
    int          otherErrors = 0;
    int          idx;
    int          due;
    int          dueQ [$];                            // cycle each decValid is due
    int          idxQ [$];

    instrDecoder instrDecoder_i (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .decValid   (decValid),
        .aluOp      (aluOp),
        .instrType  (instrType),
        .dType      (dType),
        .branchType (branchType),
        .regWrite   (regWrite),
        .memWrite   (memWrite),
        .load       (load),
        .jump       (jump),
        .auipc      (auipc),
        .illegal    (illegal)
    );

    // same packing as the pattern file
    assign actualBits = {illegal, aluOp, instrType, dType, branchType,
                         regWrite, memWrite, load, jump, auipc};

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic pickGap(output logic [1:0] pick);
        lfsrState = lfsrStep(lfsrState);
        pick[0]   = lfsrState[0];
        lfsrState = lfsrStep(lfsrState);
        pick[1]   = lfsrState[0];
    endtask

    task automatic showMismatch(input string name, input string field,
                                input logic [4:0] wantVal, input logic [4:0] gotVal);
        $display("ERR %s %s expected %0h actual %0h", name, field, wantVal, gotVal);
        testBad = 1'b1;
    endtask

    task automatic checkResult(input int testIdx, input int dueCycle);
        string       name;
        logic [19:0] want;
        logic [19:0] got;
        name    = $sformatf("t%0d_%08h", testIdx, patterns[testIdx][51:20]);
        want    = patterns[testIdx][19:0];
        got     = actualBits;
        testBad = 1'b0;
        if (cycle != dueCycle) begin
            $display("%s: decValid came at cycle %0d, one cycle after the strobe is %0d",
                     name, cycle, dueCycle);
            testBad = 1'b1;
        end
        if (want[19] != got[19]) showMismatch(name, "illegal", 5'(want[19]), 5'(got[19]));
        if (want[18:14] != got[18:14]) showMismatch(name, "aluOp", want[18:14], got[18:14]);
        if (want[13:11] != got[13:11]) showMismatch(name, "instrType", 5'(want[13:11]),
                                                    5'(got[13:11]));
        if (want[10:8] != got[10:8]) showMismatch(name, "dType", 5'(want[10:8]), 5'(got[10:8]));
        if (want[7:5] != got[7:5]) showMismatch(name, "branchType", 5'(want[7:5]), 5'(got[7:5]));
        if (want[4] != got[4]) showMismatch(name, "regWrite", 5'(want[4]), 5'(got[4]));
        if (want[3] != got[3]) showMismatch(name, "memWrite", 5'(want[3]), 5'(got[3]));
        if (want[2] != got[2]) showMismatch(name, "load", 5'(want[2]), 5'(got[2]));
        if (want[1] != got[1]) showMismatch(name, "jump", 5'(want[1]), 5'(got[1]));
        if (want[0] != got[0]) showMismatch(name, "auipc", 5'(want[0]), 5'(got[0]));
        if (testBad) begin
            $display("test %s mismatch", name);
            failCount++;
        end else begin
            $display("test %s ok", name);
            passCount++;
        end
        doneCount++;
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        $readmemh("test/decodePatterns.txt", patterns);
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;
        for (int i = 0; i < numTests; i++) begin
            pickGap(gap);
            repeat (gap) begin
                instrValid = 1'b0;
                instr      = 32'hffff_ffff;           // junk, must be ignored
                @(posedge clk);
                #2;
            end
            instrValid = 1'b1;
            instr      = patterns[i][51:20];
            dueQ.push_back(cycle + 1);
            idxQ.push_back(i);
            @(posedge clk);
            #2;
        end
        instrValid = 1'b0;
        instr      = 32'hffff_ffff;
        while (doneCount < numTests) @(posedge clk);
        repeat (3) @(posedge clk);                    // idle tail, outputs must hold
        $display("tests %0d passed %0d failed %0d other errors %0d",
                 numTests, passCount, failCount, otherErrors);
        if (failCount == 0 && otherErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // sample away from the rising edge
    always @(negedge clk) begin
        if (rstN) begin
            if (decValid) begin
                if (dueQ.size() == 0) begin
                    $display("decValid was high at cycle %0d with no strobe pending", cycle);
                    otherErrors++;
                end else begin
                    idx = idxQ.pop_front();
                    due = dueQ.pop_front();
                    checkResult(idx, due);
                    lastOut = actualBits;
                end
            end else if (actualBits != lastOut) begin
                $display("outputs changed at cycle %0d while decValid was low", cycle);
                otherErrors++;
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeoutLimit) begin
            $display("timeout: decValid stopped arriving, %0d of %0d tests decoded",
                     doneCount, numTests);
            $display("FAIL: see errors above");
            $finish;
        end
    end

endmodule
